// File: build.f
+incdir+.
math_regs_pkg.sv
math_ops_pkg.sv
math_operands_if.sv
math_regfile.sv
math_divider.sv
math_sqrt.sv
math_geometry.sv
math_readback.sv
math_coproc.sv
math_coproc_properties.sv
tb_math_coproc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the math coprocessor regression with Verilator
# exit status is the simulator's, nonzero on any $fatal or failed assertion
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    -f build.f \
    --top-module tb_math_coproc \
    -o sim_math_coproc

./obj_dir/sim_math_coproc

// File: tb_math_coproc.sv
// ========================================
// testbench for the math coprocessor
// lfsr operands, bus tasks, reference checks
// ========================================
`timescale 1ns/1ps
`include "math_macros.svh"

module tb_math_coproc;
    import math_regs_pkg::*;

    localparam int NUM_DIV    = 12;
    localparam int NUM_SQRT   = 8;
    localparam int NUM_GEO    = 10;
    localparam int NUM_RNG    = 10;
    localparam int VEC_CYCLES = 100;    // worst vector with room
    localparam int TIMEOUT_CYCLES = (NUM_DIV + NUM_SQRT + NUM_GEO + NUM_RNG) * VEC_CYCLES
                                    + 2000;

    logic                    clk;
    logic                    rst;
    logic                    cen;
    logic                    cs;
    logic                    wr_n;
    logic [`MATH_ADDR_W-1:0] addr;
    logic [7:0]              din;
    logic [7:0]              dout;
    logic [31:0]             lfsr_state;
    int                      cycles = 0;

    math_coproc u_dut (
        .clk(clk), .rst(rst), .cen(cen), .cs(cs), .wr_n(wr_n),
        .addr(addr), .din(din), .dout(dout)
    );

    bind math_coproc math_coproc_properties u_props (
        .clk(clk), .rst(rst), .cen(cen), .cs(cs), .wr_n(wr_n), .addr(addr),
        .dout(dout), .sqrt_start(ops.sqrt_start), .root(root)
    );

    always #10 clk = ~clk;  // 20 ns period

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("timeout, run not done after %0d cycles", cycles));
        end
    end

    // ========================================
    // galois lfsr stepped once per bit taken
    // ========================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    function automatic logic [15:0] rand_bits(input int nbits);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // ========================================
    // bus tasks
    // ========================================
    task automatic write_reg(input logic [`MATH_ADDR_W-1:0] a, input logic [7:0] d);
        @(posedge clk);
        cen  <= 1'b1;
        cs   <= 1'b1;
        wr_n <= 1'b0;
        addr <= a;
        din  <= d;
        @(posedge clk);     // strobe taken here
        cen  <= 1'b0;       // idle cycle before the next strobe
        wr_n <= 1'b1;
    endtask

    // high byte at the even address
    task automatic write_word(input logic [`MATH_ADDR_W-1:0] a, input logic [15:0] w);
        write_reg(a, w[15:8]);
        write_reg({a[`MATH_ADDR_W-1:1], 1'b1}, w[7:0]);
    endtask

    task automatic read_reg(input logic [`MATH_ADDR_W-1:0] a, output logic [7:0] d);
        @(posedge clk);
        cen  <= 1'b1;
        cs   <= 1'b1;
        wr_n <= 1'b1;
        addr <= a;
        @(posedge clk);     // dout loads on the single read strobe
        cen  <= 1'b0;
        @(negedge clk);
        d = dout;
    endtask

    task automatic read_check(input string name, input logic [`MATH_ADDR_W-1:0] a,
                              input logic [7:0] exp);
        logic [7:0] got;
        read_reg(a, got);
        assert (got === exp) else begin
            stop_on_error($sformatf("Mismatch %s: expected %02h, actual %02h",
                                    name, exp, got));
        end
    endtask

    // ========================================
    // stimulus and reference model
    // ========================================
    initial begin
        logic [15:0] dvd, dvs, q, r, rad, root;
        logic [15:0] radius, y1, x1, y2, x2, xd, base;
        logic [7:0]  hi, lo, step, rng_model;
        logic        apart_exp;
        longint      tgt, lo_sq, hi_sq;
        clk  = 1'b0;
        rst  = 1'b1;
        cen  = 1'b0;
        cs   = 1'b0;
        wr_n = 1'b1;
        addr = '0;
        din  = 8'h00;
        lfsr_state = 32'd76527;
        rng_model  = 8'h00;     // rng clears in reset
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // division with a zero divisor on the first vector
        for (int i = 0; i < NUM_DIV; i++) begin
            dvd = rand_bits(16);
            dvs = rand_bits(i < 6 ? 8 : 16);  // short divisors give big quotients
            if (i == 0) dvs = 16'h0000;
            if (dvs == 16'h0000) begin
                q = 16'hffff;
                r = dvd;
            end else begin
                q = dvd / dvs;
                r = dvd % dvs;
            end
            write_word(REG_DIVIDEND_HI, dvd);
            write_word(REG_DIVISOR_HI, dvs);
            read_check("div quotient hi", RD_QUOT_HI, q[15:8]);
            read_check("div quotient lo", RD_QUOT_LO, q[7:0]);
            read_check("div remainder hi", RD_REM_HI, r[15:8]);
            read_check("div remainder lo", RD_REM_LO, r[7:0]);
        end

        // square root within one lsb including both range ends
        for (int i = 0; i < NUM_SQRT; i++) begin
            rad = rand_bits(16);
            if (i == 0) rad = 16'h0000;
            if (i == 1) rad = 16'hffff;
            write_word(REG_RADICAND_HI, rad);
            repeat (`MATH_SQRT_MAX_CYCLES) @(posedge clk);
            read_reg(RD_ROOT_HI, hi);
            read_reg(RD_ROOT_LO, lo);
            root  = {hi, lo};
            tgt   = longint'(rad) << 16;
            lo_sq = (longint'(root) - 1) * (longint'(root) - 1);
            hi_sq = (longint'(root) + 1) * (longint'(root) + 1);
            assert (lo_sq <= tgt && tgt <= hi_sq) else begin
                stop_on_error($sformatf(
                    "Mismatch sqrt %04h: expected root squared near %0h, actual root %04h",
                    rad, tgt, root));
            end
        end

        // small boxes so both overlap and separation show up
        for (int i = 0; i < NUM_GEO; i++) begin
            base   = rand_bits(8) << 8;     // common high byte for all coordinates
            radius = rand_bits(5);
            y1 = base + rand_bits(6);
            x1 = base + rand_bits(6);
            y2 = base + rand_bits(6);
            x2 = base + rand_bits(6);
            write_word(REG_RADIUS_HI, radius);
            write_word(REG_Y1_HI, y1);
            write_word(REG_X1_HI, x1);
            write_word(REG_Y2_HI, y2);
            write_word(REG_X2_HI, x2);
            apart_exp = (x1 + radius < x2) || (x2 + radius < x1) ||
                        (y1 + radius < y2) || (y2 + radius < y1);
            xd = x2 - x1;   // wraps when x2 is left of x1
            read_check("geo apart", RD_APART, apart_exp ? 8'hff : 8'h00);
            read_check("geo xdist hi", RD_XDIST_HI, xd[15:8]);
            read_check("geo xdist lo", RD_XDIST_LO, xd[7:0]);
            read_check("readback y1 hi", REG_Y1_HI, y1[15:8]);
            read_check("readback y1 lo", REG_Y1_LO, y1[7:0]);
            read_check("readback x1 hi", REG_X1_HI, x1[15:8]);
            read_check("readback x1 lo", REG_X1_LO, x1[7:0]);
            read_check("readback y2 hi", REG_Y2_HI, y2[15:8]);
            read_check("readback y2 lo", REG_Y2_LO, y2[7:0]);
        end

        // random byte with an odd step
        step = 8'(rand_bits(8)) | 8'h01;
        write_reg(REG_RNG_STEP, step);
        for (int i = 0; i < NUM_RNG; i++) begin
            rng_model = rng_model + step;
            read_check("rng sequence", RD_RANDOM, rng_model);
            read_check("readback rng step", REG_RNG_STEP, step);  // must not step rng
        end

        $display("Regression passed");
        $finish;
    end

endmodule

// File: math_coproc_properties.sv
// ========================================
// bus, reset and root checks for the coprocessor
// bound onto the top level by the testbench
// ========================================
`timescale 1ns/1ps
`include "math_macros.svh"

module math_coproc_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    cen,
    input logic                    cs,
    input logic                    wr_n,
    input logic [`MATH_ADDR_W-1:0] addr,
    input logic [7:0]              dout,
    input logic                    sqrt_start,  // from the operand bundle
    input math_ops_pkg::fix88_t    root
);
    import math_regs_pkg::*;

    logic       radicand_wr;
    logic [7:0] since_start;    // edges since the last root start

    assign radicand_wr = cen && cs && !wr_n &&
        (addr == REG_RADICAND_HI || addr == REG_RADICAND_LO);

    // saturating age of the current search
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            since_start <= 8'h00;
        end else if (sqrt_start) begin
            since_start <= 8'h00;
        end else if (since_start != 8'hff) begin
            since_start <= since_start + 8'h01;
        end
    end

    // ========================================
    // assertions
    // ========================================
    // dout clear in reset and on the first edge out of it
    assert property (@(posedge clk) (rst || $fell(rst)) |-> dout == 8'h00)
        else $error("dout not zero around reset");

    // start is a single-cycle pulse
    assert property (@(posedge clk) disable iff (rst) sqrt_start |=> !sqrt_start)
        else $error("sqrt_start high on two consecutive cycles");

    // one edge after a radicand write, and only then
    assert property (@(posedge clk) disable iff (rst) radicand_wr |=> sqrt_start)
        else $error("no sqrt_start after a radicand write");
    assert property (@(posedge clk) disable iff (rst) sqrt_start |-> $past(radicand_wr))
        else $error("sqrt_start without a radicand write");

    // root frozen once the latency bound has passed
    assert property (@(posedge clk) disable iff (rst)
        (since_start >= `MATH_SQRT_MAX_CYCLES && !sqrt_start) |-> $stable(root))
        else $error("root changed after the search bound");

endmodule

// File: math_coproc.sv
// ======================================
// memory-mapped arithmetic coprocessor
// divide, square root, random, box test
// ======================================
`timescale 1ns/1ps
`include "math_macros.svh"

module math_coproc (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,    // bus clock enable
    input  logic                    cs,
    input  logic                    wr_n,
    input  logic [`MATH_ADDR_W-1:0] addr,
    input  logic [7:0]              din,
    output logic [7:0]              dout
);
    import math_ops_pkg::*;

    logic [7:0]  reg_byte;
    logic [15:0] quotient;
    logic [15:0] remainder;
    fix88_t      root;
    logic        apart;
    logic [15:0] x_distance;

    math_operands_if ops ();    // operand words to all compute blocks

    math_regfile u_regfile (
        .clk(clk), .rst(rst), .cen(cen), .cs(cs), .wr_n(wr_n),
        .addr(addr), .din(din), .ops(ops.regfile), .reg_byte(reg_byte)
    );

    math_divider u_divider (
        .clk(clk), .rst(rst), .ops(ops.compute),
        .quotient(quotient), .remainder(remainder)
    );

    math_sqrt u_sqrt (
        .clk(clk), .rst(rst), .ops(ops.compute), .root(root)
    );

    math_geometry u_geometry (
        .clk(clk), .rst(rst), .ops(ops.compute),
        .apart(apart), .x_distance(x_distance)
    );

    math_readback u_readback (
        .clk(clk), .rst(rst), .cen(cen), .cs(cs), .wr_n(wr_n),
        .addr(addr), .reg_byte(reg_byte),
        .quotient(quotient), .remainder(remainder), .root(root),
        .apart(apart), .x_distance(x_distance),
        .ops(ops.compute), .dout(dout)
    );

endmodule

// File: math_readback.sv
// ======================================
// bus read mux and random byte generator
// ======================================
`timescale 1ns/1ps
`include "math_macros.svh"

module math_readback (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic                    cs,
    input  logic                    wr_n,
    input  logic [`MATH_ADDR_W-1:0] addr,
    input  logic [7:0]              reg_byte,
    input  logic [15:0]             quotient,
    input  logic [15:0]             remainder,
    input  math_ops_pkg::fix88_t    root,
    input  logic                    apart,
    input  logic [15:0]             x_distance,
    math_operands_if.compute        ops,
    output logic [7:0]              dout
);
    import math_regs_pkg::*;

    logic [7:0] rng;
    logic [7:0] rng_nxt;
    logic       rd_stb;

    assign rd_stb  = cen && cs && wr_n;     // bus read, no wait states
    assign rng_nxt = rng + ops.rng_step;    // mod 256

    // ======================================
    // output byte, sampled every clock
    // ======================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout <= 8'h00;
            rng  <= 8'h00;
        end else begin
            case (addr)
                RD_QUOT_HI:  dout <= quotient[15:8];
                RD_QUOT_LO:  dout <= quotient[7:0];
                RD_REM_HI:   dout <= remainder[15:8];
                RD_REM_LO:   dout <= remainder[7:0];
                RD_ROOT_HI:  dout <= root[15:8];        // integer part
                RD_ROOT_LO:  dout <= root[7:0];         // fraction
                RD_RANDOM:   dout <= rng_nxt;
                RD_APART:    dout <= apart ? 8'hff : 8'h00;
                RD_XDIST_HI: dout <= x_distance[15:8];
                RD_XDIST_LO: dout <= x_distance[7:0];
                default:     dout <= reg_byte;
            endcase
            // only a real read of the random register steps it
            if (rd_stb && addr == RD_RANDOM) begin
                rng <= rng_nxt;
            end
        end
    end

endmodule

// File: math_geometry.sv
// ======================================
// bounding box test for two objects
// separation flag and x distance
// ======================================
`timescale 1ns/1ps

module math_geometry (
    input  logic              clk,
    input  logic              rst,
    math_operands_if.compute  ops,
    output logic              apart,
    output logic [15:0]       x_distance
);

    logic [15:0] x1_far, y1_far;    // object 1 far edges
    logic [15:0] x2_far, y2_far;    // object 2 far edges

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x1_far     <= 16'h0000;
            y1_far     <= 16'h0000;
            x2_far     <= 16'h0000;
            y2_far     <= 16'h0000;
            x_distance <= 16'h0000;
        end else begin
            x1_far     <= ops.x1.word + ops.radius.word;   // wraps at 16 bits
            y1_far     <= ops.y1.word + ops.radius.word;
            x2_far     <= ops.x2.word + ops.radius.word;
            y2_far     <= ops.y2.word + ops.radius.word;
            x_distance <= ops.x2.word - ops.x1.word;       // signed by wrap
        end
    end

    // no overlap when one box ends before the other starts
    assign apart = (x1_far < ops.x2.word) || (x2_far < ops.x1.word) ||
                   (y1_far < ops.y2.word) || (y2_far < ops.y1.word);

endmodule

// File: math_sqrt.sv
// ======================================
// iterative square root, 8.8 in and out
// binary search, one step every two cycles
// ======================================
`timescale 1ns/1ps

module math_sqrt (
    input  logic                 clk,
    input  logic                 rst,
    math_operands_if.compute     ops,
    output math_ops_pkg::fix88_t root
);
    import math_ops_pkg::*;

    localparam fix88_t      ROOT_SEED = 16'h8000;  // midpoint of the range
    localparam logic [14:0] STEP_SEED = 15'h4000;  // half range

    sqrt_state_e state;
    logic [14:0] step;
    logic [31:0] square;        // root squared, 16.16
    logic [31:0] target;        // radicand scaled to 16.16

    assign target = {ops.radicand.word, 16'h0000};

    // ======================================
    // search FSM
    // ======================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= SQRT_IDLE;
            root  <= 16'h0000;
            step  <= 15'h0000;
        end else if (ops.sqrt_start) begin
            // new radicand, restart from the middle
            state <= SQRT_SETTLE;
            root  <= ROOT_SEED;
            step  <= STEP_SEED;
        end else begin
            case (state)
                SQRT_SETTLE: begin
                    // out of steps, root is final
                    if (step == 15'h0000) state <= SQRT_IDLE;
                    else                  state <= SQRT_SEARCH;
                end
                SQRT_SEARCH: begin
                    if (square == target) begin
                        state <= SQRT_IDLE;     // exact hit
                    end else begin
                        if (square > target) root <= root - {1'b0, step};
                        else                 root <= root + {1'b0, step};
                        step  <= step >> 1;
                        state <= SQRT_SETTLE;
                    end
                end
                default: state <= SQRT_IDLE;    // hold root
            endcase
        end
    end

    // square follows root by one edge, used in the search phase
    always_ff @(posedge clk) begin
        square <= root * root;
    end

endmodule

// File: math_divider.sv
// ======================================
// 16-bit divider, quotient and remainder
// registered once per clock
// ======================================
`timescale 1ns/1ps

module math_divider (
    input  logic              clk,
    input  logic              rst,
    math_operands_if.compute  ops,
    output logic [15:0]       quotient,
    output logic [15:0]       remainder
);

    logic        div_zero;
    logic [15:0] quot_nxt;
    logic [15:0] rem_nxt;

    assign div_zero = (ops.divisor.word == 16'h0000);

    // zero divisor gives all ones and passes the dividend through
    always_comb begin
        if (div_zero) begin
            quot_nxt = 16'hffff;
            rem_nxt  = ops.dividend.word;
        end else begin
            quot_nxt = ops.dividend.word / ops.divisor.word;
            rem_nxt  = ops.dividend.word % ops.divisor.word;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            quotient  <= 16'h0000;
            remainder <= 16'h0000;
        end else begin
            quotient  <= quot_nxt;     // one edge behind the operands
            remainder <= rem_nxt;
        end
    end

endmodule

// File: math_regfile.sv
// ======================================
// math coprocessor register file
// 32 bytes, write decode, root start strobe
// ======================================
`timescale 1ns/1ps
`include "math_macros.svh"

module math_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic                    cs,
    input  logic                    wr_n,
    input  logic [`MATH_ADDR_W-1:0] addr,
    input  logic [7:0]              din,
    math_operands_if.regfile        ops,
    output logic [7:0]              reg_byte
);
    import math_regs_pkg::*;

    logic [7:0] mem [`MATH_REG_COUNT];
    logic       wr_stb;

    assign wr_stb = cen && cs && !wr_n;     // qualified bus write

    // ======================================
    // storage and root kick
    // ======================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MATH_REG_COUNT; i++) begin
                mem[i] <= 8'h00;
            end
            ops.sqrt_start <= 1'b0;
        end else begin
            if (wr_stb) begin
                mem[addr] <= din;
            end
            // either radicand byte restarts the search
            ops.sqrt_start <= wr_stb &&
                (addr == REG_RADICAND_HI || addr == REG_RADICAND_LO);
        end
    end

    // ======================================
    // operand words, high byte at even address
    // ======================================
    assign ops.dividend.bytes.hi = mem[REG_DIVIDEND_HI];
    assign ops.dividend.bytes.lo = mem[REG_DIVIDEND_LO];
    assign ops.divisor.bytes.hi  = mem[REG_DIVISOR_HI];
    assign ops.divisor.bytes.lo  = mem[REG_DIVISOR_LO];
    assign ops.radicand.bytes.hi = mem[REG_RADICAND_HI];
    assign ops.radicand.bytes.lo = mem[REG_RADICAND_LO];
    assign ops.radius.bytes.hi   = mem[REG_RADIUS_HI];
    assign ops.radius.bytes.lo   = mem[REG_RADIUS_LO];
    assign ops.y1.bytes.hi       = mem[REG_Y1_HI];
    assign ops.y1.bytes.lo       = mem[REG_Y1_LO];
    assign ops.x1.bytes.hi       = mem[REG_X1_HI];
    assign ops.x1.bytes.lo       = mem[REG_X1_LO];
    assign ops.y2.bytes.hi       = mem[REG_Y2_HI];
    assign ops.y2.bytes.lo       = mem[REG_Y2_LO];
    assign ops.x2.bytes.hi       = mem[REG_X2_HI];
    assign ops.x2.bytes.lo       = mem[REG_X2_LO];
    assign ops.rng_step          = mem[REG_RNG_STEP];

    assign reg_byte = mem[addr];    // raw byte for plain readback

endmodule

// File: math_operands_if.sv
// ======================================
// operand bundle from register file to compute blocks
// ======================================
`timescale 1ns/1ps

interface math_operands_if;
    import math_regs_pkg::*;

    word_pair_u dividend;
    word_pair_u divisor;
    word_pair_u radicand;       // 8.8 input to the root search
    word_pair_u radius;         // shared by both objects
    word_pair_u y1;
    word_pair_u x1;
    word_pair_u y2;
    word_pair_u x2;
    logic [7:0] rng_step;
    logic       sqrt_start;     // one cycle after a radicand write

    // register file side
    modport regfile (
        output dividend, divisor, radicand, radius,
        output y1, x1, y2, x2,
        output rng_step, sqrt_start
    );

    // divider, sqrt, geometry and readback only look
    modport compute (
        input dividend, divisor, radicand, radius,
        input y1, x1, y2, x2,
        input rng_step, sqrt_start
    );

endinterface

// File: math_ops_pkg.sv
// ======================================
// math coprocessor arithmetic types
// ======================================
package math_ops_pkg;

    // root search phase
    typedef enum logic [1:0] {
        SQRT_IDLE   = 2'd0,     // holding the last root
        SQRT_SETTLE = 2'd1,     // square of root being registered
        SQRT_SEARCH = 2'd2      // compare and step
    } sqrt_state_e;

    // unsigned 8.8 fixed point
    // integer part in [15:8], fraction in [7:0]
    typedef logic [15:0] fix88_t;

endpackage

// File: math_regs_pkg.sv
// ======================================
// math coprocessor register map
// address names and the byte/word operand view
// ======================================
package math_regs_pkg;

`include "math_macros.svh"

    // write side of the map, operands are big endian byte pairs
    typedef enum logic [`MATH_ADDR_W-1:0] {
        REG_DIVIDEND_HI = 5'h00,
        REG_DIVIDEND_LO = 5'h01,
        REG_DIVISOR_HI  = 5'h02,
        REG_DIVISOR_LO  = 5'h03,
        REG_RADICAND_HI = 5'h04,
        REG_RADICAND_LO = 5'h05,
        REG_RADIUS_HI   = 5'h06,
        REG_RADIUS_LO   = 5'h07,
        REG_Y1_HI       = 5'h08,
        REG_Y1_LO       = 5'h09,
        REG_X1_HI       = 5'h0a,
        REG_X1_LO       = 5'h0b,
        REG_Y2_HI       = 5'h0c,
        REG_Y2_LO       = 5'h0d,
        REG_X2_HI       = 5'h0e,
        REG_X2_LO       = 5'h0f,
        REG_RNG_STEP    = 5'h13     // added to rng on each read
    } reg_addr_e;

    // read side, same addresses return results
    localparam reg_addr_e RD_QUOT_HI  = REG_DIVIDEND_HI;
    localparam reg_addr_e RD_QUOT_LO  = REG_DIVIDEND_LO;
    localparam reg_addr_e RD_REM_HI   = REG_DIVISOR_HI;
    localparam reg_addr_e RD_REM_LO   = REG_DIVISOR_LO;
    localparam reg_addr_e RD_ROOT_HI  = REG_RADICAND_HI;
    localparam reg_addr_e RD_ROOT_LO  = REG_RADICAND_LO;
    localparam reg_addr_e RD_RANDOM   = REG_RADIUS_HI;
    localparam reg_addr_e RD_APART    = REG_RADIUS_LO;
    localparam reg_addr_e RD_XDIST_HI = REG_X2_HI;
    localparam reg_addr_e RD_XDIST_LO = REG_X2_LO;

    // operand written as two bytes, used as one word
    typedef union packed {
        logic [15:0] word;
        struct packed {
            logic [7:0] hi;     // even address
            logic [7:0] lo;     // odd address
        } bytes;
    } word_pair_u;

endpackage

// File: math_macros.svh
// ======================================
// math coprocessor build constants
// register map size, bus width, root latency
// ======================================
`ifndef MATH_MACROS_SVH
`define MATH_MACROS_SVH

// byte registers behind the bus
`define MATH_REG_COUNT 32

// bus address bits, covers MATH_REG_COUNT
`define MATH_ADDR_W 5

// worst case from radicand write to a settled root
// 1 start edge, 1 seed edge, 15 settle/search pairs, 2 spare
`define MATH_SQRT_MAX_CYCLES 34

`endif
